//--- common/apu_cfg.svh
`ifndef APU_CFG_SVH
`define APU_CFG_SVH

// microcode word address, 256 words of code
`define APU_CODE_AW 8

// dram request address
// byte ports 0 and 1 fill bits 15:0, port 2 fills the rest
`define APU_DRAM_AW 21

// timer counter width, loaded from one port byte
`define APU_TIMER_W 8

`endif

//--- common/apu_pkg.sv
`include "apu_cfg.svh"

package apu_pkg;

	typedef logic [15:0] instr_t;                   // one microcode word
	typedef logic [7:0] reg8_t;                     // register or port byte
	typedef logic [`APU_CODE_AW-1:0] pc_t;          // code word address
	typedef logic [`APU_DRAM_AW-1:0] dram_addr_t;
	typedef logic [15:0] dram_data_t;
	typedef logic [`APU_TIMER_W-1:0] timer_t;

	// instr[15:12], codes 9 10 11 14 run as no-ops
	typedef enum logic [3:0] {
		op_ld_imm  = 4'd0,
		op_and_imm = 4'd1,
		op_or_imm  = 4'd2,
		op_xor_imm = 4'd3,
		op_add_imm = 4'd4,
		op_sub_imm = 4'd5,
		op_alu_rr  = 4'd6,   // reg-reg ld/and/or/xor
		op_out     = 4'd7,
		op_wait    = 4'd8,   // pin wait
		op_in      = 4'd12,
		op_jr      = 4'd13,  // conditional relative jump
		op_misc    = 4'd15   // halt or nop
	} opcode_t;

	typedef enum logic [1:0] {
		st_fetch,   // code address out
		st_exec,    // word back from ram
		st_wait,    // stalled on a pin
		st_halt     // parked until host halt
	} core_state_t;

endpackage

//--- apu/apu_code_ram.sv
`timescale 1ns/1ps
`include "apu_cfg.svh"

module apu_code_ram import apu_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  code_wen,     // host byte write
	input  reg8_t                 code_wdata,
	input  logic [`APU_CODE_AW:0] code_waddr,   // byte address, bit 0 picks the half
	input  pc_t                   rd_addr,      // from core
	output instr_t                instr         // registered read data
);

	localparam int code_depth = 1 << `APU_CODE_AW;

	reg8_t  lo_byte;                // even byte waits here for its pair
	instr_t mem [code_depth];
	logic   word_wen;

	// odd byte completes the word
	assign word_wen = code_wen && code_waddr[0];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			lo_byte <= '0;
		else if (code_wen && !code_waddr[0])
			lo_byte <= code_wdata;
	end

	// read returns old data on a same-address write
	always_ff @(posedge clk)
	begin
		if (word_wen)
			mem[code_waddr[`APU_CODE_AW:1]] <= {code_wdata, lo_byte};
		instr <= mem[rd_addr];
	end

endmodule

//--- apu/apu_core.sv
`timescale 1ns/1ps
`include "apu_cfg.svh"

module apu_core import apu_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       apu_halt,     // host hold, restarts from 0
	input  instr_t     instr,        // code word, one clock after rd_addr
	input  timer_t     timer_cnt,
	input  logic       timer_end,
	input  logic       apu_strobe,   // dram strobe pin
	output pc_t        rd_addr,
	output logic       timer_wen,    // single-cycle load
	output timer_t     timer_wdata,
	output logic       apu_rdy,
	output dram_addr_t apu_addr,
	output dram_data_t apu_data_w,
	output logic       apu_req
);

	core_state_t state;
	pc_t         pc;
	reg8_t       regs [16];
	logic        flag_c, flag_z, flag_n;

	opcode_t     op;
	logic [3:0]  dst, src, rr_dst, wr_sel;
	logic        is_rr, exec, is_halt;
	reg8_t       opa, opb, src_val, port_rd;
	reg8_t       alu_res;
	logic        alu_cy, alu_wr;
	logic        jc_base, jcond;
	logic [31:0] pins_in;
	logic        pin_match;
	pc_t         pc_inc, pc_rel;

	// operand fields
	assign op     = opcode_t'(instr[15:12]);
	assign dst    = instr[11:8];
	assign src    = instr[3:0];
	assign rr_dst = instr[7:4];   // reg-reg form keeps dst low
	assign is_rr  = (op == op_alu_rr);
	assign wr_sel = is_rr ? rr_dst : dst;

	assign opa     = regs[wr_sel];
	assign opb     = is_rr ? regs[src] : instr[7:0];
	assign src_val = regs[src];

	// no execute in a cycle where the host holds the core
	assign exec    = (state == st_exec) && !apu_halt;
	assign is_halt = (op == op_misc) && (instr[11:0] == 12'hfff);

	always_comb
	begin
		alu_res = opb;
		alu_cy  = flag_c;   // carry kept unless add or sub
		alu_wr  = 1'b1;
		case (op)
			op_ld_imm:  alu_res = opb;
			op_and_imm: alu_res = opa & opb;
			op_or_imm:  alu_res = opa | opb;
			op_xor_imm: alu_res = opa ^ opb;
			op_add_imm: {alu_cy, alu_res} = {1'b0, opa} + {1'b0, opb};
			op_sub_imm: {alu_cy, alu_res} = {1'b0, opa} - {1'b0, opb};  // bit 8 is borrow
			op_alu_rr:
			begin
				case (instr[11:10])
					2'd0: alu_res = opb;
					2'd1: alu_res = opa & opb;
					2'd2: alu_res = opa | opb;
					default: alu_res = opa ^ opb;
				endcase
			end
			default: alu_wr = 1'b0;
		endcase
	end

	// conditions 4..7 are 0..3 inverted
	always_comb
	begin
		case (instr[10:9])
			2'd0: jc_base = 1'b1;
			2'd1: jc_base = flag_c;
			2'd2: jc_base = flag_z;
			default: jc_base = flag_n;
		endcase
	end
	assign jcond = jc_base ^ instr[11];

	// input pins, unused ones read 0
	assign pins_in   = {30'b0, apu_strobe, timer_end};
	assign pin_match = (pins_in[instr[4:0]] == instr[11]);

	assign port_rd = (src == 4'd0) ? reg8_t'(timer_cnt) : 8'h00;  // only the timer is readable

	assign pc_inc = pc_t'(pc + 1'b1);
	assign pc_rel = pc_t'(pc_inc + pc_t'(signed'(instr[8:0])));   // rel9 from the next word

	assign rd_addr = pc;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= st_fetch;
			pc      <= '0;
			apu_rdy <= 1'b0;
		end
		else if (apu_halt)
		begin
			state   <= st_fetch;
			pc      <= '0;
			apu_rdy <= 1'b0;
		end
		else
		begin
			case (state)
				st_fetch: state <= st_exec;   // ram registers the word
				st_exec:
				begin
					case (op)
						op_wait: state <= st_wait;
						op_jr:
						begin
							state <= st_fetch;
							pc    <= jcond ? pc_rel : pc_inc;
						end
						op_misc:
						begin
							if (is_halt)
							begin
								state   <= st_halt;   // pc parks on the halt word
								apu_rdy <= 1'b1;
							end
							else
							begin
								state <= st_fetch;
								pc    <= pc_inc;
							end
						end
						default:
						begin
							state <= st_fetch;
							pc    <= pc_inc;
						end
					endcase
				end
				st_wait:
				begin
					if (pin_match)
					begin
						state <= st_fetch;
						pc    <= pc_inc;
					end
				end
				default: state <= st_halt;   // stay until apu_halt
			endcase
		end
	end

	// register file and flags
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			flag_c <= 1'b0;
			flag_z <= 1'b0;
			flag_n <= 1'b0;
		end
		else if (exec && alu_wr)
		begin
			regs[wr_sel] <= alu_res;
			flag_c       <= alu_cy;
			flag_z       <= (alu_res == 8'h00);
			flag_n       <= alu_res[7];
		end
		else if (exec && (op == op_in))
			regs[dst] <= port_rd;   // flags untouched
	end

	// output ports
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			apu_addr   <= '0;
			apu_data_w <= '0;
			apu_req    <= 1'b0;
		end
		else if (exec && (op == op_out))
		begin
			case (dst)
				4'd0: apu_addr[7:0]   <= src_val;
				4'd1: apu_addr[15:8]  <= src_val;
				4'd2: apu_addr[`APU_DRAM_AW-1:16] <= src_val[`APU_DRAM_AW-17:0];  // top bits dropped
				4'd3: apu_data_w[7:0] <= src_val;
				4'd4: apu_data_w[15:8] <= src_val;
				4'd6: apu_req         <= src_val[0];   // pin port
				default: ;
			endcase
		end
	end

	// port 5 goes straight to the timer
	assign timer_wen   = exec && (op == op_out) && (dst == 4'd5);
	assign timer_wdata = timer_t'(src_val);

endmodule

//--- hdl/apu_timer.sv
`timescale 1ns/1ps

module apu_timer import apu_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   wen,       // load strobe
	input  timer_t wdata,
	output timer_t ctr,
	output logic   cnt_end    // count at zero after a load
);

	logic armed;   // set by the first load

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ctr   <= '0;
			armed <= 1'b0;
		end
		else if (wen)
		begin
			ctr   <= wdata;
			armed <= 1'b1;
		end
		else if (ctr != '0)
			ctr <= timer_t'(ctr - 1'b1);   // stops at zero
	end

	// low out of reset, no load seen yet
	assign cnt_end = armed && (ctr == '0);

endmodule

//--- hdl/apu_top.sv
`timescale 1ns/1ps
`include "apu_cfg.svh"

module apu_top import apu_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  apu_halt,     // host hold
	input  logic                  code_wen,     // microcode byte load
	input  reg8_t                 code_wdata,
	input  logic [`APU_CODE_AW:0] code_waddr,
	input  logic                  apu_strobe,   // dram strobe
	output logic                  apu_rdy,
	output dram_addr_t            apu_addr,
	output dram_data_t            apu_data_w,
	output logic                  apu_req
);

	instr_t instr;
	pc_t    rd_addr;
	logic   timer_wen;
	timer_t timer_wdata;
	timer_t timer_cnt;
	logic   timer_end;

	// host-loaded code store
	apu_code_ram code_ram_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.code_wen   (code_wen),
		.code_wdata (code_wdata),
		.code_waddr (code_waddr),
		.rd_addr    (rd_addr),
		.instr      (instr)
	);

	apu_core core_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.apu_halt    (apu_halt),
		.instr       (instr),
		.timer_cnt   (timer_cnt),
		.timer_end   (timer_end),
		.apu_strobe  (apu_strobe),
		.rd_addr     (rd_addr),
		.timer_wen   (timer_wen),
		.timer_wdata (timer_wdata),
		.apu_rdy     (apu_rdy),
		.apu_addr    (apu_addr),
		.apu_data_w  (apu_data_w),
		.apu_req     (apu_req)
	);

	// loaded through core port 5, read back on in port 0
	apu_timer timer_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.wen     (timer_wen),
		.wdata   (timer_wdata),
		.ctr     (timer_cnt),
		.cnt_end (timer_end)
	);

endmodule

//--- tb/apu_chk.sv
`timescale 1ns/1ps

module apu_chk import apu_pkg::*;
(
	input logic        clk,
	input logic        arst_n,
	input logic        apu_halt,
	input logic        apu_rdy,
	input core_state_t state,
	input pc_t         rd_addr,
	input logic        timer_wen
);

	// ready only from the parked state
	rdy_in_halt: assert property (@(posedge clk) disable iff (!arst_n)
		apu_rdy |-> (state == st_halt))
		else $error("apu_rdy high while core not in st_halt");

	// host hold pulls the fetch address back to word 0
	halt_pc_zero: assert property (@(posedge clk) disable iff (!arst_n)
		apu_halt |=> (rd_addr == '0))
		else $error("rd_addr not 0 after apu_halt");

	timer_wen_single: assert property (@(posedge clk) disable iff (!arst_n)
		timer_wen |=> !timer_wen)   // one load per out instruction
		else $error("timer_wen held longer than one cycle");

endmodule

bind apu_core apu_chk chk_inst (
	.clk       (clk),
	.arst_n    (arst_n),
	.apu_halt  (apu_halt),
	.apu_rdy   (apu_rdy),
	.state     (state),
	.rd_addr   (rd_addr),
	.timer_wen (timer_wen)
);

//--- tb/apu_tb.sv
`timescale 1ns/1ps
`include "apu_cfg.svh"

module apu_tb import apu_pkg::*;
();

	localparam int n_tests = 6;

	logic                  clk;
	logic                  arst_n;
	logic                  apu_halt;
	logic                  code_wen;
	reg8_t                 code_wdata;
	logic [`APU_CODE_AW:0] code_waddr;
	logic                  apu_strobe;
	logic                  apu_rdy;
	dram_addr_t            apu_addr;
	dram_data_t            apu_data_w;
	logic                  apu_req;

	// test table, word 0 of each program is the leftmost literal
	logic [255:0] prog [n_tests];
	int           prog_len [n_tests];
	dram_addr_t   exp_addr [n_tests];
	dram_data_t   exp_data [n_tests];
	logic         exp_req [n_tests];
	int           strobe_dly [n_tests];   // cycles before apu_strobe rises, 0 for none
	int           restart_at [n_tests];   // host halt this many cycles into the run
	string        test_name [n_tests];

	integer seed;
	int     errors;
	int     checks;
	int     cycle_limit;
	int     run_cycles = 0;

	apu_top apu_top_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.apu_halt   (apu_halt),
		.code_wen   (code_wen),
		.code_wdata (code_wdata),
		.code_waddr (code_waddr),
		.apu_strobe (apu_strobe),
		.apu_rdy    (apu_rdy),
		.apu_addr   (apu_addr),
		.apu_data_w (apu_data_w),
		.apu_req    (apu_req)
	);

	always #2 clk = ~clk;   // 4 ns period

	// only counts cycles where the core is free to run
	always @(posedge clk)
	begin
		if (arst_n && !apu_halt)
		begin
			run_cycles++;
			if (run_cycles > cycle_limit)
			begin
				$display("Timeout: no halt reached within %0d run cycles", cycle_limit);
				$display("Checks failed");
				$finish;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	begin
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	end
	endtask

	task automatic set_row(input int t, input string name, input int len, input dram_addr_t addr,
		input dram_data_t data, input logic req, input int dly, input int restart);
	begin
		test_name[t]  = name;
		prog_len[t]   = len;
		exp_addr[t]   = addr;
		exp_data[t]   = data;
		exp_req[t]    = req;
		strobe_dly[t] = dly;
		restart_at[t] = restart;
	end
	endtask

	// byte pairs, low byte at the even address
	task automatic load_program(input int t);
		logic [15:0] word;
	begin
		for (int k = 0; k < prog_len[t]; k++)
		begin
			word = prog[t][(prog_len[t] - 1 - k) * 16 +: 16];
			@(negedge clk);
			code_wen   = 1'b1;
			code_waddr = 2 * k;
			code_wdata = word[7:0];
			@(negedge clk);
			code_waddr = 2 * k + 1;
			code_wdata = word[15:8];
		end
		@(negedge clk);
		code_wen = 1'b0;
	end
	endtask

	task automatic run_test(input int t);
		int err_before;
	begin
		err_before = errors;
		@(negedge clk);
		apu_halt   = 1'b1;
		apu_strobe = 1'b0;
		load_program(t);
		apu_halt = 1'b0;   // runs from word 0
		if (restart_at[t] > 0)
		begin
			repeat (restart_at[t]) @(negedge clk);
			apu_halt = 1'b1;   // hold mid program
			@(negedge clk);
			check_value("apu_rdy", apu_rdy, 0);
			apu_halt = 1'b0;
		end
		if (strobe_dly[t] > 0)
		begin
			repeat (strobe_dly[t])
			begin
				@(negedge clk);
				check_value("apu_rdy", apu_rdy, 0);   // parked on the wait
			end
			check_value("apu_req", apu_req, 1);
			apu_strobe = 1'b1;
		end
		while (!apu_rdy)
			@(negedge clk);
		check_value("apu_addr", apu_addr, exp_addr[t]);
		check_value("apu_data_w", apu_data_w, exp_data[t]);
		check_value("apu_req", apu_req, exp_req[t]);
		if (errors == err_before)
			$display("test %0d %s: ok", t + 1, test_name[t]);
		else
			$display("test %0d %s: %0d errors", t + 1, test_name[t], errors - err_before);
	end
	endtask

	initial
	begin
		clk        = 1'b0;
		arst_n     = 1'b0;
		apu_halt   = 1'b1;
		code_wen   = 1'b0;
		code_wdata = '0;
		code_waddr = '0;
		apu_strobe = 1'b0;
		errors     = 0;
		checks     = 0;
		seed       = 32'hbe47;

		// 0xc8 + 0x5a carries, jr c skips the ld of 0xee
		prog[0] = {16'h00C8, 16'h405A, 16'h0111, 16'hD201, 16'h01EE, 16'h7300, 16'h7401,
			16'hFFFF};
		set_row(0, "arithmetic", 8, 21'h0, 16'h1122, 1'b0, 0, 0);
		// and/xor/or leave r2 0x3c, r3 0x0c; xor 0xbc gives 0x80 with n set
		prog[1] = {16'h02F0, 16'h033C, 16'h6423, 16'h6C32, 16'h6823, 16'hDC01, 16'h0300,
			16'h32BC, 16'hD601, 16'h0380, 16'h7302, 16'h7403, 16'hFFFF};
		set_row(1, "logic flags", 13, 21'h0, 16'h0C80, 1'b0, 0, 0);
		// 0xeb on port 2 keeps only 0x0b
		prog[2] = {16'h0534, 16'h0612, 16'h07EB, 16'h7005, 16'h7106, 16'h7207, 16'hFFFF};
		set_row(2, "address", 7, 21'h0B1234, 16'h0C80, 1'b0, 0, 0);
		prog[3] = {16'h0001, 16'h7600, 16'h8801, 16'h0000, 16'h7600, 16'h01A5, 16'h7301,
			16'hFFFF};
		set_row(3, "strobe wait", 8, 21'h0B1234, 16'h0CA5, 1'b0, 10 + ($random(seed) & 15), 0);
		// load 9, wait for end, read count back
		prog[4] = {16'h0209, 16'h7502, 16'h8800, 16'hC300, 16'h7303, 16'hFFFF};
		set_row(4, "timer", 6, 21'h0B1234, 16'h0C00, 1'b0, 0, 0);
		// r9 counts passes through word 0 and the restart makes it 2
		prog[5] = {16'h4901, 16'h0810, 16'h4810, 16'h4810, 16'h7308, 16'h7409, 16'hFFFF};
		set_row(5, "halt restart", 7, 21'h0B1234, 16'h0230, 1'b0, 0, 6);

		cycle_limit = 50 + 9;   // margin plus the timer load of test 5
		for (int t = 0; t < n_tests; t++)
			cycle_limit += 2 * prog_len[t] + strobe_dly[t] + restart_at[t];

		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		for (int t = 0; t < n_tests; t++)
			run_test(t);

		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+common
common/apu_pkg.sv
apu/apu_code_ram.sv
apu/apu_core.sv
hdl/apu_timer.sv
hdl/apu_top.sv
tb/apu_chk.sv
tb/apu_tb.sv
